// File: common/pio_isa_pkg.sv
/* Instruction set types for the I/O state machine. Field positions follow the
   16-bit encoding and are fixed; WAIT and IRQ opcodes decode but do nothing */
package pio_isa_pkg;

  typedef logic [31:0] word_t;      // X, Y, ISR, OSR and FIFO data
  typedef logic [31:0] pins_t;      // One bit per pin level
  typedef logic [15:0] instr_t;
  typedef logic [4:0]  pc_t;        // 32-entry program store
  typedef logic [4:0]  delay_t;
  typedef logic [5:0]  shift_cnt_t; // 1 to 32

  typedef enum logic [2:0] {
    OP_JMP       = 3'd0,
    OP_WAIT      = 3'd1,
    OP_IN        = 3'd2,
    OP_OUT       = 3'd3,
    OP_PUSH_PULL = 3'd4, // Bit 7 selects PULL
    OP_MOV       = 3'd5,
    OP_IRQ       = 3'd6,
    OP_SET       = 3'd7
  } opcode_e;

  // Codes 4 and 5 are not used as sources
  typedef enum logic [2:0] {
    SRC_PINS = 3'd0,
    SRC_X    = 3'd1,
    SRC_Y    = 3'd2,
    SRC_NULL = 3'd3,
    SRC_ISR  = 3'd6,
    SRC_OSR  = 3'd7
  } src_e;

  typedef enum logic [2:0] {
    DST_PINS = 3'd0,
    DST_X    = 3'd1,
    DST_Y    = 3'd2,
    DST_ISR  = 3'd6, // MOV only
    DST_OSR  = 3'd7  // MOV only
  } dst_e;

  typedef enum logic [1:0] {
    MOV_NONE, MOV_INVERT, MOV_REVERSE, MOV_RESERVED
  } mov_op_e;

  // Four-phase exchange toward the outside FIFOs
  typedef enum logic [1:0] {
    FIFO_IDLE, FIFO_REQ, FIFO_RELEASE, FIFO_DONE
  } fifo_state_e;

endpackage

// File: common/pio_cfg_pkg.sv
/* Configuration register map. Address 3 is unused and writes to it are dropped */
package pio_cfg_pkg;

  typedef logic [1:0] cfg_addr_t;

  localparam cfg_addr_t CFG_CTRL = 2'd0;
  localparam cfg_addr_t CFG_WRAP = 2'd1;
  localparam cfg_addr_t CFG_PINS = 2'd2;

  typedef logic [4:0] pin_base_t;
  typedef logic [2:0] set_count_t; // 0 to 5
  typedef logic [5:0] out_count_t; // 0 to 32

  // CFG_CTRL bits
  localparam int CTRL_ENABLE_BIT    = 0;
  localparam int CTRL_IN_RIGHT_BIT  = 1;
  localparam int CTRL_OUT_RIGHT_BIT = 2;

  // CFG_WRAP fields
  localparam int WRAP_TARGET_LSB = 0;
  localparam int WRAP_END_LSB    = 8;

  // CFG_PINS fields
  localparam int PINS_SET_BASE_LSB  = 0;
  localparam int PINS_SET_COUNT_LSB = 8;
  localparam int PINS_OUT_BASE_LSB  = 16;
  localparam int PINS_OUT_COUNT_LSB = 24;

endpackage

// File: hdl/pio_cfg_regs.sv
`timescale 1ns/1ns
/* Registers written over a four-phase req/ack handshake. The master must hold
   address and data until cfg_ack and drop cfg_req before the next write */
module pio_cfg_regs (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cfg_req,
  input  pio_cfg_pkg::cfg_addr_t  cfg_addr,
  input  pio_isa_pkg::word_t      cfg_wdata,
  output logic                    cfg_ack,
  output logic                    enable,
  output logic                    in_shift_right,
  output logic                    out_shift_right,
  output pio_isa_pkg::pc_t        wrap_target,
  output pio_isa_pkg::pc_t        wrap_end,
  output pio_cfg_pkg::pin_base_t  set_base,
  output pio_cfg_pkg::set_count_t set_count,
  output pio_cfg_pkg::pin_base_t  out_base,
  output pio_cfg_pkg::out_count_t out_count
);
  import pio_cfg_pkg::*;

  logic wr;

  assign wr = cfg_req && !cfg_ack; // First cycle of a new request

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg_ack         <= 1'b0;
      enable          <= 1'b0;
      in_shift_right  <= 1'b0;
      out_shift_right <= 1'b0;
      wrap_target     <= '0;
      wrap_end        <= '0;
      set_base        <= '0;
      set_count       <= '0;
      out_base        <= '0;
      out_count       <= '0;
    end else begin
      cfg_ack <= cfg_req; // Rises after the write, falls one cycle after req drops
      if (wr) begin
        case (cfg_addr)
          CFG_CTRL: begin
            enable          <= cfg_wdata[CTRL_ENABLE_BIT];
            in_shift_right  <= cfg_wdata[CTRL_IN_RIGHT_BIT];
            out_shift_right <= cfg_wdata[CTRL_OUT_RIGHT_BIT];
          end
          CFG_WRAP: begin
            wrap_target <= cfg_wdata[WRAP_TARGET_LSB +: $bits(wrap_target)];
            wrap_end    <= cfg_wdata[WRAP_END_LSB +: $bits(wrap_end)];
          end
          CFG_PINS: begin
            set_base  <= cfg_wdata[PINS_SET_BASE_LSB +: $bits(set_base)];
            set_count <= cfg_wdata[PINS_SET_COUNT_LSB +: $bits(set_count)];
            out_base  <= cfg_wdata[PINS_OUT_BASE_LSB +: $bits(out_base)];
            out_count <= cfg_wdata[PINS_OUT_COUNT_LSB +: $bits(out_count)];
          end
          default: ; // Unmapped
        endcase
      end
    end
  end

  // A raised request is not withdrawn before it is acknowledged
  a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
    cfg_req && !cfg_ack |=> cfg_req);

endmodule

// File: sm/pio_exec.sv
`timescale 1ns/1ns
/* Decode and execute. PUSH and PULL always block; WAIT and IRQ run as NOPs.
   IN reads the pins from pin 0, SET and OUT/MOV PINS rotate around pin 31 */
module pio_exec (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    enable,
  input  pio_isa_pkg::instr_t     instr,
  input  pio_isa_pkg::pins_t      in_pins,
  input  pio_isa_pkg::word_t      isr,
  input  pio_isa_pkg::word_t      osr,
  input  pio_isa_pkg::word_t      osr_shifted_out,
  input  pio_cfg_pkg::pin_base_t  set_base,
  input  pio_cfg_pkg::set_count_t set_count,
  input  pio_cfg_pkg::pin_base_t  out_base,
  input  pio_cfg_pkg::out_count_t out_count,
  input  logic                    fifo_done,
  input  pio_isa_pkg::word_t      pull_word,
  input  logic                    delaying,
  output pio_isa_pkg::pins_t      pins,
  output logic                    stall,
  output logic                    jump,
  output pio_isa_pkg::pc_t        jump_addr,
  output pio_isa_pkg::delay_t     delay,
  output logic                    isr_load,
  output logic                    isr_shift,
  output logic                    osr_load,
  output logic                    osr_shift,
  output pio_isa_pkg::shift_cnt_t shift_cnt,
  output pio_isa_pkg::word_t      shift_in_word,
  output pio_isa_pkg::word_t      load_word,
  output logic                    fifo_start,
  output logic                    fifo_is_pull
);
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  opcode_e    opcode;
  logic [2:0] op1;
  logic [4:0] op2;
  dst_e       dst;
  src_e       mov_src;
  mov_op_e    mov_op;
  logic       active;
  logic       retire;
  word_t      x;
  word_t      y;
  word_t      src_val;
  word_t      mov_val;
  word_t      xy_wdata;
  logic       x_wr;
  logic       y_wr;
  logic       x_dec;
  logic       y_dec;
  logic       pin_wr;
  word_t      pin_wdata;
  pin_base_t  pin_base;
  out_count_t pin_cnt;

  assign opcode    = opcode_e'(instr[15:13]);
  assign delay     = instr[12:8];
  assign op1       = instr[7:5];
  assign op2       = instr[4:0];
  assign dst       = dst_e'(op1);
  assign mov_src   = src_e'(op2[2:0]);
  assign mov_op    = mov_op_e'(op2[4:3]);
  assign jump_addr = op2;

  assign active       = enable && !delaying;
  assign stall        = !active || (opcode == OP_PUSH_PULL && !fifo_done);
  assign retire       = !stall;
  assign fifo_start   = active && opcode == OP_PUSH_PULL;
  assign fifo_is_pull = op1[2];

  function automatic word_t select_src(input src_e s);
    case (s)
      SRC_PINS: return in_pins;
      SRC_X:    return x;
      SRC_Y:    return y;
      SRC_ISR:  return isr;
      SRC_OSR:  return osr;
      default:  return '0; // NULL and unused codes
    endcase
  endfunction

  // Writes cnt bits of val from base upwards, wrapping past pin 31
  function automatic pins_t write_pins(input pins_t cur, input word_t val,
                                       input pin_base_t base, input out_count_t cnt);
    pins_t     p;
    pin_base_t idx;
    p = cur;
    for (int i = 0; i < 32; i++) begin
      idx = base + pin_base_t'(i);
      if (i < int'(cnt)) p[idx] = val[i];
    end
    return p;
  endfunction

  always_comb begin
    src_val = select_src(mov_src);
    case (mov_op)
      MOV_INVERT:  mov_val = ~src_val;
      MOV_REVERSE: mov_val = {<<{src_val}};
      default:     mov_val = src_val;
    endcase
  end

  always_comb begin
    jump          = 1'b0;
    x_dec         = 1'b0;
    y_dec         = 1'b0;
    x_wr          = 1'b0;
    y_wr          = 1'b0;
    xy_wdata      = mov_val;
    pin_wr        = 1'b0;
    pin_wdata     = mov_val;
    pin_base      = out_base;
    pin_cnt       = out_count;
    isr_load      = 1'b0;
    isr_shift     = 1'b0;
    osr_load      = 1'b0;
    osr_shift     = 1'b0;
    load_word     = mov_val;
    shift_in_word = select_src(src_e'(op1));
    shift_cnt     = (op2 == '0) ? shift_cnt_t'(32) : shift_cnt_t'(op2); // 0 encodes 32
    case (opcode)
      OP_JMP: begin
        case (op1)
          3'd0: jump = 1'b1;
          3'd1: jump = (x == '0);
          3'd2: begin
            jump  = (x != '0);
            x_dec = jump; // Post-decrement only when taken
          end
          3'd3: jump = (y == '0);
          3'd4: begin
            jump  = (y != '0);
            y_dec = jump;
          end
          3'd5: jump = (x != y);
          default: jump = 1'b0; // Reserved
        endcase
      end
      OP_IN: isr_shift = 1'b1;
      OP_OUT: begin
        osr_shift = 1'b1;
        xy_wdata  = osr_shifted_out;
        pin_wdata = osr_shifted_out;
        pin_wr    = (dst == DST_PINS);
        x_wr      = (dst == DST_X);
        y_wr      = (dst == DST_Y);
      end
      OP_PUSH_PULL: begin
        if (fifo_is_pull) begin
          osr_load  = fifo_done;
          load_word = pull_word;
        end else begin
          isr_load  = fifo_done; // ISR cleared once pushed
          load_word = '0;
        end
      end
      OP_MOV: begin
        pin_wr   = (dst == DST_PINS);
        x_wr     = (dst == DST_X);
        y_wr     = (dst == DST_Y);
        isr_load = (dst == DST_ISR);
        osr_load = (dst == DST_OSR);
      end
      OP_SET: begin
        xy_wdata  = word_t'(op2);
        pin_wdata = word_t'(op2);
        pin_base  = set_base;
        pin_cnt   = out_count_t'(set_count);
        pin_wr    = (dst == DST_PINS);
        x_wr      = (dst == DST_X);
        y_wr      = (dst == DST_Y);
      end
      default: ; // WAIT, IRQ
    endcase
    if (!active) begin
      isr_load  = 1'b0;
      isr_shift = 1'b0;
      osr_load  = 1'b0;
      osr_shift = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x    <= '0;
      y    <= '0;
      pins <= '0;
    end else if (retire) begin
      if (x_wr) x <= xy_wdata;
      else if (x_dec) x <= x - word_t'(1);
      if (y_wr) y <= xy_wdata;
      else if (y_dec) y <= y - word_t'(1);
      if (pin_wr) pins <= write_pins(pins, pin_wdata, pin_base, pin_cnt);
    end
  end

  // Shift registers only move on the cycle the instruction retires
  a_no_strobe_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
    stall |-> !(isr_load || isr_shift || osr_load || osr_shift));

endmodule

// File: sm/pio_shift_regs.sv
`timescale 1ns/1ns
/* ISR and OSR. A shift count of 32 replaces or empties the whole register;
   loads win over shifts when both are strobed */
module pio_shift_regs (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    stall,
  input  logic                    in_shift_right,
  input  logic                    out_shift_right,
  input  logic                    isr_load,
  input  logic                    isr_shift,
  input  logic                    osr_load,
  input  logic                    osr_shift,
  input  pio_isa_pkg::shift_cnt_t shift_cnt,
  input  pio_isa_pkg::word_t      shift_in_word,
  input  pio_isa_pkg::word_t      load_word,
  output pio_isa_pkg::word_t      isr,
  output pio_isa_pkg::word_t      osr,
  output pio_isa_pkg::word_t      osr_shifted_out
);
  import pio_isa_pkg::*;

  logic [63:0] isr_cat;
  word_t       isr_shifted;
  word_t       osr_remain;

  always_comb begin
    if (in_shift_right) begin
      isr_cat     = {shift_in_word, isr} >> shift_cnt; // New bits enter at the top
      isr_shifted = isr_cat[31:0];
    end else begin
      // Low bits of the input moved to the top of the lower half first
      isr_cat     = {isr, shift_in_word << (6'd32 - shift_cnt)} << shift_cnt;
      isr_shifted = isr_cat[63:32];
    end
  end

  always_comb begin
    if (out_shift_right) begin
      osr_shifted_out = osr & ~(word_t'('1) << shift_cnt); // Low bits
      osr_remain      = osr >> shift_cnt;
    end else begin
      osr_shifted_out = osr >> (6'd32 - shift_cnt); // Top bits, right-aligned
      osr_remain      = osr << shift_cnt;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      isr <= '0;
      osr <= '0;
    end else if (!stall) begin
      if (isr_load) isr <= load_word;
      else if (isr_shift) isr <= isr_shifted;
      if (osr_load) osr <= load_word;
      else if (osr_shift) osr <= osr_remain;
    end
  end

endmodule

// File: sm/pio_fifo_port.sv
`timescale 1ns/1ns
/* One four-phase exchange per start. A start seen in DONE is ignored, so the
   core must drop or change its request on the retiring edge */
module pio_fifo_port (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               fifo_start,
  input  logic               fifo_is_pull,
  input  pio_isa_pkg::word_t isr,
  input  logic               push_ack,
  input  logic               pull_ack,
  input  pio_isa_pkg::word_t pull_data,
  output logic               push_req,
  output pio_isa_pkg::word_t push_data,
  output logic               pull_req,
  output logic               fifo_done,
  output pio_isa_pkg::word_t pull_word
);
  import pio_isa_pkg::*;

  fifo_state_e state;
  logic        is_pull;
  logic        ack;

  assign ack       = is_pull ? pull_ack : push_ack; // Ack of the open exchange
  assign fifo_done = (state == FIFO_DONE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= FIFO_IDLE;
      is_pull  <= 1'b0;
      push_req <= 1'b0;
      pull_req <= 1'b0;
    end else begin
      case (state)
        FIFO_IDLE: if (fifo_start) begin
          is_pull  <= fifo_is_pull;
          push_req <= !fifo_is_pull;
          pull_req <= fifo_is_pull;
          state    <= FIFO_REQ;
        end
        FIFO_REQ: if (ack) begin
          push_req <= 1'b0;
          pull_req <= 1'b0;
          state    <= FIFO_RELEASE;
        end
        FIFO_RELEASE: if (!ack) state <= FIFO_DONE;
        default: state <= FIFO_IDLE; // DONE lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FIFO_IDLE && fifo_start && !fifo_is_pull) push_data <= isr;
    if (state == FIFO_REQ && is_pull && pull_ack) pull_word <= pull_data; // First ack edge
  end

  a_one_req: assert property (@(posedge clk) disable iff (!arst_n)
    !(push_req && pull_req));

endmodule

// File: sm/pio_pc.sv
`timescale 1ns/1ns
/* Program counter and delay counter. A running delay counts down even while
   the core is disabled */
module pio_pc (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                stall,
  input  logic                jump,
  input  pio_isa_pkg::pc_t    jump_addr,
  input  pio_isa_pkg::delay_t delay,
  input  pio_isa_pkg::pc_t    wrap_target,
  input  pio_isa_pkg::pc_t    wrap_end,
  output pio_isa_pkg::pc_t    pc,
  output logic                delaying
);
  import pio_isa_pkg::*;

  delay_t delay_cnt;

  assign delaying = (delay_cnt != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc        <= '0;
      delay_cnt <= '0;
    end else if (delaying) begin
      delay_cnt <= delay_cnt - delay_t'(1);
    end else if (!stall) begin
      delay_cnt <= delay; // Retiring instruction starts its delay
      if (jump) pc <= jump_addr;
      else if (pc == wrap_end) pc <= wrap_target;
      else pc <= pc + pc_t'(1);
    end
  end

endmodule

// File: hdl/pio_sm_top.sv
`timescale 1ns/1ns
/* State machine with its configuration block. The program store and both FIFOs
   are outside; instr must be valid for pc in the same cycle */
module pio_sm_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cfg_req,
  input  pio_cfg_pkg::cfg_addr_t cfg_addr,
  input  pio_isa_pkg::word_t     cfg_wdata,
  input  pio_isa_pkg::instr_t    instr,
  input  pio_isa_pkg::pins_t     in_pins,
  input  logic                   push_ack,
  input  logic                   pull_ack,
  input  pio_isa_pkg::word_t     pull_data,
  output logic                   cfg_ack,
  output pio_isa_pkg::pc_t       pc,
  output pio_isa_pkg::pins_t     pins,
  output logic                   push_req,
  output pio_isa_pkg::word_t     push_data,
  output logic                   pull_req
);
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  // Configuration
  logic       enable;
  logic       in_shift_right;
  logic       out_shift_right;
  pc_t        wrap_target;
  pc_t        wrap_end;
  pin_base_t  set_base;
  set_count_t set_count;
  pin_base_t  out_base;
  out_count_t out_count;

  // Sequencing
  logic   stall;
  logic   jump;
  pc_t    jump_addr;
  delay_t delay;
  logic   delaying;

  // Shift registers
  logic       isr_load;
  logic       isr_shift;
  logic       osr_load;
  logic       osr_shift;
  shift_cnt_t shift_cnt;
  word_t      shift_in_word;
  word_t      load_word;
  word_t      isr;
  word_t      osr;
  word_t      osr_shifted_out;

  // FIFO port
  logic  fifo_start;
  logic  fifo_is_pull;
  logic  fifo_done;
  word_t pull_word;

  pio_cfg_regs   u_cfg   (.*);
  pio_exec       u_exec  (.*);
  pio_shift_regs u_shift (.*);
  pio_fifo_port  u_fifo  (.*);
  pio_pc         u_pc    (.*);

endmodule

// File: verif/pio_prog_table.svh
/* Test programs with configuration words and expected results. Each program
   holds at most 8 instructions and must end in a loop on end_pc */
`ifndef PIO_PROG_TABLE_SVH
`define PIO_PROG_TABLE_SVH

localparam int N_TESTS = 6;

instr_t prog_tab     [N_TESTS][8];
word_t  cfg_tab      [N_TESTS][3]; // CTRL, WRAP, PINS
word_t  pull_tab     [N_TESTS];
pins_t  in_pins_tab  [N_TESTS];
word_t  push_tab     [N_TESTS][4];
int     n_push_tab   [N_TESTS];
int     n_instr_tab  [N_TESTS];
pc_t    end_pc_tab   [N_TESTS];
pins_t  exp_pins_tab [N_TESTS];

function automatic instr_t encode_instr(input opcode_e op, input delay_t d,
                                        input logic [2:0] a, input logic [4:0] b);
  return {op, d, a, b};
endfunction

task automatic fill_tables();
  for (int t = 0; t < N_TESTS; t++) begin
    for (int i = 0; i < 8; i++) prog_tab[t][i] = '0;
    for (int i = 0; i < 4; i++) push_tab[t][i] = '0;
    cfg_tab[t][0] = 32'h1;       // Enable, both shifts left
    cfg_tab[t][1] = 32'h0000_1F00; // Wrap from 31 to 0
    cfg_tab[t][2] = '0;
    pull_tab[t] = '0;
    in_pins_tab[t] = '0;
    n_push_tab[t] = 0;
    exp_pins_tab[t] = '0;
  end
  // SET PINS with delay, pins 6..4
  prog_tab[0][0] = encode_instr(OP_SET, 5'd3, DST_PINS, 5'd5);
  prog_tab[0][1] = encode_instr(OP_JMP, 5'd0, 3'd0, 5'd1);
  cfg_tab[0][2] = 32'h0000_0304;
  n_instr_tab[0] = 2;
  end_pc_tab[0] = 5'd1;
  exp_pins_tab[0] = 32'h0000_0050;
  // X loop shifting bit 0 of X into the ISR from the top
  prog_tab[1][0] = encode_instr(OP_SET, 5'd0, DST_X, 5'd3);
  prog_tab[1][1] = encode_instr(OP_IN, 5'd0, SRC_X, 5'd1);
  prog_tab[1][2] = encode_instr(OP_JMP, 5'd0, 3'd2, 5'd1);
  prog_tab[1][3] = encode_instr(OP_PUSH_PULL, 5'd0, 3'd0, 5'd0);
  prog_tab[1][4] = encode_instr(OP_JMP, 5'd0, 3'd0, 5'd4);
  cfg_tab[1][0] = 32'h3;
  n_instr_tab[1] = 5;
  end_pc_tab[1] = 5'd4;
  n_push_tab[1] = 1;
  push_tab[1][0] = 32'h5000_0000; // Bits 1,0,1,0 enter at bit 31
  // PULL then OUT right-shifted to pins and Y
  prog_tab[2][0] = encode_instr(OP_PUSH_PULL, 5'd0, 3'd4, 5'd0);
  prog_tab[2][1] = encode_instr(OP_OUT, 5'd0, DST_PINS, 5'd8);
  prog_tab[2][2] = encode_instr(OP_OUT, 5'd0, DST_Y, 5'd8);
  prog_tab[2][3] = encode_instr(OP_MOV, 5'd0, DST_ISR, {MOV_NONE, SRC_Y});
  prog_tab[2][4] = encode_instr(OP_PUSH_PULL, 5'd0, 3'd0, 5'd0);
  prog_tab[2][5] = encode_instr(OP_JMP, 5'd0, 3'd0, 5'd5);
  cfg_tab[2][0] = 32'h5;
  cfg_tab[2][2] = 32'h0800_0000;
  pull_tab[2] = 32'hA5C3_9617;
  n_instr_tab[2] = 6;
  end_pc_tab[2] = 5'd5;
  n_push_tab[2] = 1;
  push_tab[2][0] = 32'h0000_0096;
  exp_pins_tab[2] = 32'h0000_0017;
  // MOV invert then reverse
  prog_tab[3][0] = encode_instr(OP_MOV, 5'd0, DST_X, {MOV_INVERT, SRC_PINS});
  prog_tab[3][1] = encode_instr(OP_MOV, 5'd0, DST_ISR, {MOV_REVERSE, SRC_X});
  prog_tab[3][2] = encode_instr(OP_PUSH_PULL, 5'd0, 3'd0, 5'd0);
  prog_tab[3][3] = encode_instr(OP_JMP, 5'd0, 3'd0, 5'd3);
  in_pins_tab[3] = 32'h1234_5678;
  n_instr_tab[3] = 4;
  end_pc_tab[3] = 5'd3;
  n_push_tab[3] = 1;
  push_tab[3][0] = 32'hE195_D3B7;
  // Wrapped loop of clear, IN PINS 4, PUSH
  prog_tab[4][0] = encode_instr(OP_IN, 5'd0, SRC_NULL, 5'd0);
  prog_tab[4][1] = encode_instr(OP_IN, 5'd0, SRC_PINS, 5'd4);
  prog_tab[4][2] = encode_instr(OP_PUSH_PULL, 5'd0, 3'd0, 5'd0);
  cfg_tab[4][1] = 32'h0000_0200;
  in_pins_tab[4] = 32'hDEAD_BEE9;
  n_instr_tab[4] = 3;
  end_pc_tab[4] = 5'd0;
  n_push_tab[4] = 4;
  for (int i = 0; i < 4; i++) push_tab[4][i] = 32'h9;
  // Jump conditions with X = Y = 0; a wrong branch leaves pins at 0, 2 or 3
  prog_tab[5][0] = encode_instr(OP_JMP, 5'd0, 3'd5, 5'd2);
  prog_tab[5][1] = encode_instr(OP_SET, 5'd0, DST_PINS, 5'd1);
  prog_tab[5][2] = encode_instr(OP_JMP, 5'd0, 3'd1, 5'd4);
  prog_tab[5][3] = encode_instr(OP_SET, 5'd0, DST_PINS, 5'd2);
  prog_tab[5][4] = encode_instr(OP_JMP, 5'd0, 3'd3, 5'd6);
  prog_tab[5][5] = encode_instr(OP_SET, 5'd0, DST_PINS, 5'd3);
  prog_tab[5][6] = encode_instr(OP_JMP, 5'd0, 3'd6, 5'd1); // Reserved, never taken
  prog_tab[5][7] = encode_instr(OP_JMP, 5'd0, 3'd0, 5'd7);
  cfg_tab[5][2] = 32'h0000_0500;
  n_instr_tab[5] = 8;
  end_pc_tab[5] = 5'd7;
  exp_pins_tab[5] = 32'h0000_0001;
endtask

`endif

// File: verif/tb_pio_sm.sv
`timescale 1ns/1ns
/* Testbench for pio_sm_top. FIFO responders ack after 0 to 3 random cycles;
   each test ends when its pushes are seen and pc sits on its end loop */
module tb_pio_sm;
  import pio_isa_pkg::*;
  import pio_cfg_pkg::*;

  `include "pio_prog_table.svh"

  localparam int CYCLES_PER_INSTR = 64;

  logic      clk;
  logic      arst_n;
  logic      cfg_req;
  cfg_addr_t cfg_addr;
  word_t     cfg_wdata;
  instr_t    instr;
  pins_t     in_pins;
  logic      push_ack;
  logic      pull_ack;
  word_t     pull_data;
  logic      cfg_ack;
  pc_t       pc;
  pins_t     pins;
  logic      push_req;
  word_t     push_data;
  logic      pull_req;

  instr_t      cur_prog [8];
  int          cur_test;
  int          pushes_seen;
  logic [15:0] lfsr_state;
  int          push_dly;
  int          pull_dly;

  pio_sm_top UUT (.*);

  assign instr = (pc < pc_t'(8)) ? cur_prog[pc[2:0]] : '0; // Program store

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic int ack_delay();
    logic [1:0] d;
    d[1] = lfsr_bit();
    d[0] = lfsr_bit();
    return int'(d);
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: test %0d %s got %h expected %h",
               $time, cur_test, what, got, exp);
      $display("Verification failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_pins(input pins_t got, input pins_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: test %0d %s got %h expected %h",
               $time, cur_test, what, got, exp);
      $display("Verification failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic stop_with(input string why);
    $display("Verification failed");
    $fatal(1, "%s", why);
  endtask

  task automatic record_push(input word_t w);
    if (pushes_seen >= n_push_tab[cur_test]) begin
      stop_with($sformatf("test %0d pushed more words than expected", cur_test));
    end
    check_word(w, push_tab[cur_test][pushes_seen], "push data");
    pushes_seen++;
  endtask

  // Push responder
  always begin
    @(negedge clk);
    if (arst_n && push_req && !push_ack) begin
      record_push(push_data);
      push_dly = ack_delay();
      repeat (push_dly) @(negedge clk);
      push_ack = 1'b1;
      while (push_req) @(negedge clk);
      push_ack = 1'b0;
    end
  end

  // Pull responder, data valid with ack
  always begin
    @(negedge clk);
    if (arst_n && pull_req && !pull_ack) begin
      pull_dly = ack_delay();
      repeat (pull_dly) @(negedge clk);
      pull_data = pull_tab[cur_test];
      pull_ack  = 1'b1;
      while (pull_req) @(negedge clk);
      pull_ack  = 1'b0;
    end
  end

  task automatic write_cfg(input cfg_addr_t a, input word_t d);
    int n;
    n = 0;
    @(negedge clk);
    cfg_addr  = a;
    cfg_wdata = d;
    cfg_req   = 1'b1;
    while (!cfg_ack) begin
      @(negedge clk);
      n++;
      if (n > CYCLES_PER_INSTR) stop_with("configuration write was never acknowledged");
    end
    @(negedge clk); // One more cycle with req held
    cfg_req = 1'b0;
    while (cfg_ack) begin
      @(negedge clk);
      n++;
      if (n > CYCLES_PER_INSTR) stop_with("configuration ack never dropped");
    end
  endtask

  task automatic run_test(input int t);
    int cycles;
    int limit;
    @(negedge clk);
    arst_n = 1'b0;
    for (int i = 0; i < 8; i++) cur_prog[i] = prog_tab[t][i];
    in_pins = in_pins_tab[t];
    repeat (5) @(negedge clk);
    cur_test    = t;
    pushes_seen = 0;
    arst_n      = 1'b1;
    write_cfg(CFG_WRAP, cfg_tab[t][1]);
    write_cfg(CFG_PINS, cfg_tab[t][2]);
    write_cfg(CFG_CTRL, cfg_tab[t][0]); // Enable last
    cycles = 0;
    limit  = CYCLES_PER_INSTR * n_instr_tab[t];
    while (!(pushes_seen >= n_push_tab[t] && pc == end_pc_tab[t])) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        stop_with($sformatf("timeout: test %0d did not finish in %0d cycles", t, limit));
      end
    end
    check_pins(pins, exp_pins_tab[t], "final pins");
  endtask

  initial begin
    arst_n      = 1'b0;
    cfg_req     = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    in_pins     = '0;
    push_ack    = 1'b0;
    pull_ack    = 1'b0;
    pull_data   = '0;
    cur_test    = 0;
    pushes_seen = 0;
    lfsr_state  = 16'd49885;
    for (int i = 0; i < 8; i++) cur_prog[i] = '0;
    fill_tables();
    for (int t = 0; t < N_TESTS; t++) run_test(t);
    $display("Verification passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verif
common/pio_isa_pkg.sv
common/pio_cfg_pkg.sv
hdl/pio_cfg_regs.sv
sm/pio_exec.sv
sm/pio_shift_regs.sv
sm/pio_fifo_port.sv
sm/pio_pc.sv
hdl/pio_sm_top.sv
verif/tb_pio_sm.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench; exit status is the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_pio_sm \
  -Mdir obj_dir -f verilog.f \
  && ./obj_dir/Vtb_pio_sm \
  || exit 1
